//--- adc_display_top.f
+incdir+source
source/i2c_pkg.sv
source/display_pkg.sv
source/adc_sample_if.sv
source/adc_i2c_reader.sv
source/bcd_formatter.sv
source/seg_scanner.sv
source/adc_display_top.sv
tests/adc_display_tb.sv

//--- Bender.yml
package:
  name: adc_display

sources:
  - include_dirs:
      - source
    files:
      - source/i2c_pkg.sv
      - source/display_pkg.sv
      - source/adc_sample_if.sv
      - source/adc_i2c_reader.sv
      - source/bcd_formatter.sv
      - source/seg_scanner.sv
      - source/adc_display_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/adc_display_tb.sv

//--- tests/adc_display_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the ADC display with a converter model
// on the I2C pins and frames read back from the segments
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "adc_display_defines.svh"

module adc_display_tb
	import display_pkg::*;
();
	localparam int         STOP_LIMIT    = `ADC_POLL_CYCLES + 1000;
	localparam int         SETTLE_CYCLES = 2 * `ADC_SCL_DIV + 12; // rest of STOP, strobe, conversion
	localparam seg_frame_t RESET_FRAME   = '{d7: DIG_A, default: DIG_BLANK};

	logic         sys_clk;
	logic         sys_rst_n;
	logic         scl;
	wire          sda;
	seg_pattern_t seg_number;
	logic [7:0]   seg_choice;

	// converter model
	logic       model_oe;
	logic       prev_scl;
	logic       prev_sda;
	logic [1:0] mode;         // 0 master writes, 1 model sends, 2 idle
	logic [7:0] rx_sr;
	logic [7:0] tx_sr;
	logic       withhold_ack; // next address byte left without ACK
	logic       ack_withheld;
	logic       master_nack;
	logic [7:0] serve_q[$];
	int         bit_cnt;
	int         byte_idx;
	int         stop_cnt;
	logic [7:0] prev_choice;

	assign sda = model_oe ? 1'b0 : 1'bz;
	pullup (sda);

	adc_display_top uut (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.scl        (scl),
		.sda        (sda),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

	always #4 sys_clk = ~sys_clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_frame(input seg_frame_t got, input seg_frame_t exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %0t: frame %h, expected %h", $time, got, exp));
	endtask

	task automatic check_i2c_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %0t: %s byte %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_line(input logic got, input logic exp, input string what);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	// A marker, blanks, then the number without leading zeros
	function automatic seg_frame_t expected_frame(input logic [7:0] value, input logic nack);
		seg_frame_t f;
		int         hundreds;
		int         tens;
		hundreds = value / 100;
		tens     = (value / 10) % 10;
		f        = '{d7: DIG_A, default: DIG_BLANK};
		if (nack) begin
			f.d7 = DIG_E;
			f.d6 = DIG_R;
			f.d5 = DIG_R;
		end else begin
			if (hundreds != 0)
				f.d2 = digit_code_e'(4'(hundreds));
			if (hundreds != 0 || tens != 0)
				f.d1 = digit_code_e'(4'(tens));
			f.d0 = digit_code_e'(4'(value % 10));
		end
		return f;
	endfunction

	// active low {dp, g..a} back to a digit code
	task automatic decode_segments(input seg_pattern_t pattern, output digit_code_e code);
		case (pattern)
			8'hC0: code = DIG_0;
			8'hF9: code = DIG_1;
			8'hA4: code = DIG_2;
			8'hB0: code = DIG_3;
			8'h99: code = DIG_4;
			8'h92: code = DIG_5;
			8'h82: code = DIG_6;
			8'hF8: code = DIG_7;
			8'h80: code = DIG_8;
			8'h90: code = DIG_9;
			8'h88: code = DIG_A;
			8'h86: code = DIG_E;
			8'hAF: code = DIG_R;
			8'hFF: code = DIG_BLANK;
			default: abort_run($sformatf("[ERROR] %0t: unknown segment pattern %h", $time, pattern));
		endcase
	endtask

	task automatic capture_frame(output seg_frame_t frame);
		logic [31:0] bits;
		digit_code_e code;
		int          limit;
		int          n;
		int          i;
		for (i = 0; i < 8; i++) begin
			limit = (i == 0) ? 8 * `SEG_SCAN_CYCLES + 4 : `SEG_SCAN_CYCLES + 4;
			n     = 0;
			while (seg_choice !== ~(8'b1 << i) && n < limit) begin
				@(negedge sys_clk);
				n++;
			end
			if (seg_choice !== ~(8'b1 << i))
				abort_run($sformatf("timed out waiting for digit %0d to be selected", i));
			decode_segments(seg_number, code);
			bits[4*i +: 4] = code;
		end
		frame = bits;
	endtask

	task automatic wait_stop(input int count_before);
		int n;
		n = 0;
		while (stop_cnt == count_before && n < STOP_LIMIT) begin
			@(negedge sys_clk);
			n++;
		end
		if (stop_cnt == count_before)
			abort_run("timed out waiting for the reader to finish a transaction");
	endtask

	// one poll served by the model, then the shown frame read back
	task automatic run_reading(input logic [7:0] value, input logic nack);
		seg_frame_t got;
		int         stops_before;
		stops_before = stop_cnt;
		if (nack)
			withhold_ack = 1'b1;
		else
			serve_q.push_back(value);
		wait_stop(stops_before);
		repeat (SETTLE_CYCLES) @(negedge sys_clk);
		capture_frame(got);
		check_frame(got, expected_frame(value, nack));
	endtask

	// converter model sampling the bus and driving SDA on the falling clock edge
	always @(negedge sys_clk) begin
		if (sys_rst_n) begin
			if (scl && prev_scl && prev_sda && !sda) begin
				bit_cnt = 0; // START or repeated START
				mode    = 2'd0;
			end else if (scl && prev_scl && !prev_sda && sda) begin
				if (!ack_withheld && !master_nack)
					abort_run($sformatf("[ERROR] %0t: STOP without NACK on the data byte", $time));
				stop_cnt++;
				byte_idx     = 0;
				mode         = 2'd2;
				ack_withheld = 1'b0;
				withhold_ack = 1'b0;
				master_nack  = 1'b0;
			end else if (scl && !prev_scl && mode != 2'd2) begin
				if (mode == 2'd0 && bit_cnt < 8)
					rx_sr = {rx_sr[6:0], sda};
				if (mode == 2'd1 && bit_cnt == 8)
					master_nack = sda;
				bit_cnt++;
			end else if (!scl && prev_scl && mode != 2'd2) begin
				if (mode == 2'd0 && bit_cnt == 8) begin
					case (byte_idx)
						0:       check_i2c_byte(rx_sr, 8'hA8, "address write");
						1:       check_i2c_byte(rx_sr, 8'h00, "register");
						default: check_i2c_byte(rx_sr, 8'hA9, "address read");
					endcase
					ack_withheld = withhold_ack && byte_idx == 0;
					model_oe    <= !ack_withheld;
				end else if (bit_cnt == 8) begin
					model_oe <= 1'b0; // master NACKs the data byte
				end else if (bit_cnt == 9) begin
					bit_cnt   = 0;
					model_oe <= 1'b0;
					if (ack_withheld || mode == 2'd1) begin
						mode = 2'd2;
					end else if (byte_idx == 2) begin
						if (serve_q.size() == 0)
							abort_run("converter model was asked for a byte but has none queued");
						tx_sr     = serve_q.pop_front();
						mode      = 2'd1;
						model_oe <= !tx_sr[7];
					end else begin
						byte_idx++;
					end
				end else if (mode == 2'd1) begin
					model_oe <= !tx_sr[7 - bit_cnt];
				end
			end
			prev_scl = scl;
			prev_sda = sda;
		end
	end

	// digit selects rotate 0..7, restart at 0 on a new frame
	always @(negedge sys_clk) begin
		if (sys_rst_n) begin
			if ($countones(~seg_choice) != 1)
				abort_run($sformatf("[ERROR] %0t: select %b not one-hot low", $time, seg_choice));
			if (seg_choice !== prev_choice && seg_choice !== {prev_choice[6:0], prev_choice[7]}
					&& seg_choice !== 8'hFE)
				abort_run($sformatf("[ERROR] %0t: select %b out of order after %b",
					$time, seg_choice, prev_choice));
			prev_choice = seg_choice;
		end
	end

	initial begin
		seg_frame_t got;
		logic [7:0] value;
		int         n;
		void'($urandom(32'h77a0_3542));
		sys_clk      = 1'b0;
		sys_rst_n    = 1'b0;
		model_oe     = 1'b0;
		prev_scl     = 1'b1;
		prev_sda     = 1'b1;
		mode         = 2'd2;
		rx_sr        = '0;
		tx_sr        = '0;
		withhold_ack = 1'b0;
		ack_withheld = 1'b0;
		master_nack  = 1'b0;
		bit_cnt      = 0;
		byte_idx     = 0;
		stop_cnt     = 0;
		prev_choice  = 8'hFE;
		repeat (2) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		@(negedge sys_clk);
		check_line(scl, 1'b1, "scl after reset");
		check_line(sda, 1'b1, "sda after reset");
		capture_frame(got);
		check_frame(got, RESET_FRAME);
		for (n = 0; n < 10; n++)
			run_reading(8'(n), 1'b0);
		run_reading(8'd10, 1'b0);
		run_reading(8'd99, 1'b0);
		run_reading(8'd100, 1'b0);
		run_reading(8'd255, 1'b0);
		run_reading(8'd0, 1'b1); // address not acknowledged
		for (n = 0; n < 20; n++) begin
			value = 8'($urandom);
			run_reading(value, 1'b0);
		end
		$display("** PASS **");
		$finish;
	end

endmodule

//--- source/adc_display_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// board top: I2C ADC reading shown in decimal on
// the eight-digit seven-segment display
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module adc_display_top
	import display_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	output logic       scl,
	inout  wire        sda,        // open drain, pull-up on the board
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice
);
	seg_frame_t frame;
	logic       frame_upd;
	logic       sda_oe;
	logic       sda_in;

	adc_sample_if smp_if ();

	assign sda    = sda_oe ? 1'b0 : 1'bz;
	assign sda_in = sda;

	adc_i2c_reader u_reader (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.smp       (smp_if.producer),
		.scl       (scl),
		.sda_oe    (sda_oe),
		.sda_in    (sda_in)
	);

	bcd_formatter u_formatter (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.smp       (smp_if.consumer),
		.frame     (frame),
		.frame_upd (frame_upd)
	);

	seg_scanner u_scanner (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.frame      (frame),
		.frame_upd  (frame_upd),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

endmodule

//--- source/seg_scanner.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// drives the eight digits one at a time from the
// held frame, selects and segments active low
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "adc_display_defines.svh"

module seg_scanner
	import display_pkg::*;
(
	input  logic         sys_clk,
	input  logic         sys_rst_n,
	input  seg_frame_t   frame,
	input  logic         frame_upd,
	output seg_pattern_t seg_number,
	output logic [7:0]   seg_choice
);
	localparam int SCAN  = `SEG_SCAN_CYCLES;
	localparam int CNT_W = (SCAN > 1) ? $clog2(SCAN) : 1;

	logic [CNT_W-1:0] dwell_cnt;
	logic [2:0]       digit_idx;
	logic [31:0]      frame_bits;
	digit_code_e      cur_digit;

	// segments {dp, g, f, e, d, c, b, a}, dp always off
	function automatic seg_pattern_t seg_decode(input digit_code_e d);
		case (d)
			DIG_0:   return 8'hC0;
			DIG_1:   return 8'hF9;
			DIG_2:   return 8'hA4;
			DIG_3:   return 8'hB0;
			DIG_4:   return 8'h99;
			DIG_5:   return 8'h92;
			DIG_6:   return 8'h82;
			DIG_7:   return 8'hF8;
			DIG_8:   return 8'h80;
			DIG_9:   return 8'h90;
			DIG_A:   return 8'h88;
			DIG_E:   return 8'h86;
			DIG_R:   return 8'hAF; // segments e and g
			default: return 8'hFF; // blank
		endcase
	endfunction

	assign frame_bits = frame;
	assign cur_digit  = digit_code_e'(frame_bits[{digit_idx, 2'b00} +: 4]);
	assign seg_number = seg_decode(cur_digit);
	assign seg_choice = ~(8'b0000_0001 << digit_idx);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			dwell_cnt <= '0;
			digit_idx <= '0;
		end else if (frame_upd) begin
			dwell_cnt <= '0; // new frame starts at digit 0
			digit_idx <= '0;
		end else if (dwell_cnt == CNT_W'(SCAN - 1)) begin
			dwell_cnt <= '0;
			digit_idx <= digit_idx + 1'b1;
		end else begin
			dwell_cnt <= dwell_cnt + 1'b1;
		end
	end

endmodule

//--- source/bcd_formatter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// turns each reading into a decimal display frame
// by an 8-step double-dabble, holds it until the next
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module bcd_formatter
	import display_pkg::*;
(
	input  logic           sys_clk,
	input  logic           sys_rst_n,
	adc_sample_if.consumer smp,
	output seg_frame_t     frame,
	output logic           frame_upd
);
	localparam seg_frame_t IDLE_FRAME = '{d7: DIG_A, default: DIG_BLANK};
	localparam seg_frame_t ERR_FRAME  = '{d7: DIG_E, d6: DIG_R, d5: DIG_R, default: DIG_BLANK};

	logic        conv_act;
	logic [2:0]  step;
	logic [7:0]  bin_sr;
	logic [11:0] bcd;     // hundreds, tens, units
	logic [11:0] bcd_adj;
	logic [11:0] bcd_nxt;
	logic        take;

	function automatic logic [3:0] add3(input logic [3:0] d);
		return (d > 4'd4) ? d + 4'd3 : d;
	endfunction

	// leading zeros blanked, units always shown
	function automatic seg_frame_t number_frame(input logic [11:0] v);
		seg_frame_t f;
		f    = '{d7: DIG_A, default: DIG_BLANK};
		f.d2 = (v[11:8] == 4'd0) ? DIG_BLANK : digit_code_e'(v[11:8]);
		f.d1 = (v[11:4] == 8'd0) ? DIG_BLANK : digit_code_e'(v[7:4]);
		f.d0 = digit_code_e'(v[3:0]);
		return f;
	endfunction

	assign take    = smp.sample_vld && !conv_act;
	assign bcd_adj = {add3(bcd[11:8]), add3(bcd[7:4]), add3(bcd[3:0])};
	assign bcd_nxt = {bcd_adj[10:0], bin_sr[7]};

	always_ff @(posedge sys_clk) begin
		if (take) begin
			bin_sr <= smp.sample;
			bcd    <= '0;
		end else if (conv_act) begin
			bin_sr <= {bin_sr[6:0], 1'b0};
			bcd    <= bcd_nxt;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			conv_act  <= 1'b0;
			step      <= '0;
			frame     <= IDLE_FRAME;
			frame_upd <= 1'b0;
		end else begin
			frame_upd <= 1'b0;
			if (conv_act) begin
				step <= step + 1'b1;
				if (step == 3'd7) begin
					conv_act  <= 1'b0;
					frame     <= number_frame(bcd_nxt); // last shift feeds the frame
					frame_upd <= 1'b1;
				end
			end else if (take) begin
				conv_act <= 1'b1;
				step     <= '0;
			end else if (smp.nack_err) begin
				frame     <= ERR_FRAME;
				frame_upd <= 1'b1;
			end
		end
	end

endmodule

//--- source/adc_i2c_reader.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I2C master polling one register of the converter
// write address, restart, read one byte, NACK, STOP
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "adc_display_defines.svh"

module adc_i2c_reader
	import i2c_pkg::*;
(
	input  logic           sys_clk,
	input  logic           sys_rst_n,
	adc_sample_if.producer smp,
	output logic           scl,
	output logic           sda_oe, // high pulls SDA low
	input  logic           sda_in
);
	localparam int DIV    = `ADC_SCL_DIV;
	localparam int POLL   = `ADC_POLL_CYCLES;
	localparam int DIV_W  = (DIV > 1) ? $clog2(DIV) : 1;
	localparam int POLL_W = $clog2(POLL + 1);

	i2c_state_e        state;
	i2c_phase_e        phase;
	i2c_byte_e         byte_sel;
	logic [DIV_W-1:0]  div_cnt;
	logic [POLL_W-1:0] poll_cnt;
	logic [2:0]        bit_cnt;
	logic [7:0]        tx_byte;
	logic [7:0]        rx_byte;
	logic              nack_seen;
	logic              phase_tick; // last cycle of a quarter
	logic              bit_end;
	logic              sample_pt;  // SCL is high here
	logic              scl_nxt;
	logic              oe_nxt;

	assign phase_tick = (div_cnt == DIV_W'(DIV - 1));
	assign bit_end    = phase_tick && (phase == PH_3);
	assign sample_pt  = phase_tick && (phase == PH_2);
	assign smp.busy   = (state != ST_IDLE);
	assign smp.sample = rx_byte;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state          <= ST_IDLE;
			phase          <= PH_0;
			byte_sel       <= BYTE_ADDR_WR;
			div_cnt        <= '0;
			poll_cnt       <= '0;
			bit_cnt        <= '0;
			nack_seen      <= 1'b0;
			smp.sample_vld <= 1'b0;
			smp.nack_err   <= 1'b0;
		end else begin
			smp.sample_vld <= 1'b0;
			smp.nack_err   <= 1'b0;
			if (state == ST_IDLE) begin
				div_cnt <= '0;
				phase   <= PH_0;
				if (poll_cnt == POLL_W'(POLL - 1)) begin
					poll_cnt <= '0;
					state    <= ST_START;
				end else begin
					poll_cnt <= poll_cnt + 1'b1;
				end
			end else begin
				div_cnt <= phase_tick ? '0 : div_cnt + 1'b1;
				if (phase_tick)
					phase <= i2c_phase_e'(phase + 2'd1);
				if (state == ST_GET_ACK && sample_pt && sda_in)
					nack_seen <= 1'b1; // SDA left high by the slave
				if (bit_end) begin
					case (state)
						ST_START: begin
							state     <= ST_SEND;
							byte_sel  <= BYTE_ADDR_WR;
							bit_cnt   <= '0;
							nack_seen <= 1'b0;
						end
						ST_SEND: begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == 3'd7)
								state <= ST_GET_ACK;
						end
						ST_GET_ACK: begin
							if (nack_seen) begin
								state <= ST_STOP; // abort
							end else begin
								case (byte_sel)
									BYTE_ADDR_WR: begin
										byte_sel <= BYTE_REG;
										state    <= ST_SEND;
									end
									BYTE_REG: state <= ST_RESTART;
									default:  state <= ST_READ;
								endcase
							end
						end
						ST_RESTART: begin
							byte_sel <= BYTE_ADDR_RD;
							state    <= ST_SEND;
						end
						ST_READ: begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == 3'd7)
								state <= ST_NACK;
						end
						ST_NACK: state <= ST_STOP;
						ST_STOP: begin
							state          <= ST_IDLE;
							smp.sample_vld <= !nack_seen;
							smp.nack_err   <= nack_seen;
						end
						default: state <= ST_IDLE;
					endcase
				end
			end
		end
	end

	// byte shifters
	always_ff @(posedge sys_clk) begin
		if (bit_end && state == ST_START)
			tx_byte <= {`ADC_DEV_ADDR, 1'b0};
		else if (bit_end && state == ST_RESTART)
			tx_byte <= {`ADC_DEV_ADDR, 1'b1};
		else if (bit_end && state == ST_GET_ACK && byte_sel == BYTE_ADDR_WR)
			tx_byte <= `ADC_REG_ADDR;
		else if (bit_end && state == ST_SEND)
			tx_byte <= {tx_byte[6:0], 1'b0}; // MSB first
		if (sample_pt && state == ST_READ)
			rx_byte <= {rx_byte[6:0], sda_in};
	end

	// line levels per state and quarter
	always_comb begin
		scl_nxt = 1'b1;
		oe_nxt  = 1'b0;
		case (state)
			ST_START: begin
				scl_nxt = (phase != PH_3);
				oe_nxt  = (phase == PH_2) || (phase == PH_3); // SDA falls with SCL high
			end
			ST_RESTART: begin
				scl_nxt = (phase == PH_1) || (phase == PH_2);
				oe_nxt  = (phase == PH_2) || (phase == PH_3);
			end
			ST_SEND: begin
				scl_nxt = (phase == PH_1) || (phase == PH_2);
				oe_nxt  = !tx_byte[7];
			end
			ST_GET_ACK, ST_READ, ST_NACK: begin
				scl_nxt = (phase == PH_1) || (phase == PH_2); // SDA released
			end
			ST_STOP: begin
				scl_nxt = (phase != PH_0);
				oe_nxt  = (phase == PH_0) || (phase == PH_1); // SDA rises with SCL high
			end
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scl    <= 1'b1;
			sda_oe <= 1'b0;
		end else begin
			scl    <= scl_nxt;
			sda_oe <= oe_nxt;
		end
	end

endmodule

//--- source/adc_sample_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reading and status from the I2C reader to the
// BCD formatter, all driven by the reader
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface adc_sample_if;

	logic [7:0] sample;     // byte read from the converter
	logic       sample_vld; // one-cycle, sample valid now
	logic       nack_err;   // one-cycle, converter did not ack
	logic       busy;       // transaction on the bus

	modport producer (
		output sample, sample_vld, nack_err, busy
	);

	modport consumer (
		input sample, sample_vld, nack_err, busy
	);

endinterface

//--- source/display_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// digit codes, frame and segment types for the
// seven-segment path from formatter to scanner
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package display_pkg;

	typedef enum logic [3:0] {
		DIG_0     = 4'd0,
		DIG_1     = 4'd1,
		DIG_2     = 4'd2,
		DIG_3     = 4'd3,
		DIG_4     = 4'd4,
		DIG_5     = 4'd5,
		DIG_6     = 4'd6,
		DIG_7     = 4'd7,
		DIG_8     = 4'd8,
		DIG_9     = 4'd9,
		DIG_BLANK = 4'd10,
		DIG_E     = 4'd11, // error
		DIG_R     = 4'd13, // lower-case r of the error word
		DIG_A     = 4'd15  // leading marker
	} digit_code_e;

	// d0 is the rightmost digit
	typedef struct packed {
		digit_code_e d7;
		digit_code_e d6;
		digit_code_e d5;
		digit_code_e d4;
		digit_code_e d3;
		digit_code_e d2;
		digit_code_e d1;
		digit_code_e d0;
	} seg_frame_t;

	typedef logic [7:0] seg_pattern_t; // active low, {dp, g..a}

endpackage

//--- source/i2c_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I2C master bus-protocol types
// imported by the converter reader
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package i2c_pkg;

	typedef enum logic [2:0] {
		ST_IDLE,    // waiting for the poll interval
		ST_START,
		ST_SEND,    // shifting one byte out
		ST_GET_ACK,
		ST_RESTART, // repeated start before the read
		ST_READ,
		ST_NACK,    // master ends the read
		ST_STOP
	} i2c_state_e;

	// quarters of one SCL bit
	typedef enum logic [1:0] {PH_0, PH_1, PH_2, PH_3} i2c_phase_e;

	// which byte the master is sending
	typedef enum logic [1:0] {BYTE_ADDR_WR, BYTE_REG, BYTE_ADDR_RD} i2c_byte_e;

endpackage

//--- source/adc_display_defines.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// build-time constants for the ADC polling display
// include in any module that needs bus or scan timing
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ADC_DISPLAY_DEFINES_SVH
`define ADC_DISPLAY_DEFINES_SVH

// converter on the I2C bus
`define ADC_DEV_ADDR 7'h54 // 7-bit device address
`define ADC_REG_ADDR 8'h00 // conversion result register

// idle cycles between STOP and next START
// kept short so a simulation sees many readings
`define ADC_POLL_CYCLES 2000

// sys_clk cycles per quarter of one SCL bit
`define ADC_SCL_DIV 4

// dwell per display digit, in sys_clk cycles
`define SEG_SCAN_CYCLES 16

`endif
